/* common/fetchTypes.sv */
// Fetch front end encodings
// Next-PC select, cache controller state and the bimodal counter with its step rule
package fetchTypes;

    // Two-bit saturating branch counter
    typedef enum logic [1:0] {
        strongNotTaken = 2'd0,
        weakNotTaken   = 2'd1,
        weakTaken      = 2'd2,
        strongTaken    = 2'd3
    } CounterState;

    // Counters start just below the taken threshold
    localparam CounterState COUNTER_INIT = weakNotTaken;

    // Instruction cache controller
    typedef enum logic {
        idle,
        refill
    } CacheState;

    // Source of the next fetch block address
    typedef enum logic [1:0] {
        selSequential,
        selPredicted,
        selHold,
        selRedirect
    } NextPcSel;

    // One saturating step toward the resolved direction
    function automatic CounterState nextCounter(input CounterState cur, input logic taken);
        CounterState nxt;
        case (cur)
            strongNotTaken: nxt = taken ? weakNotTaken : strongNotTaken;
            weakNotTaken:   nxt = taken ? weakTaken : strongNotTaken;
            weakTaken:      nxt = taken ? strongTaken : weakNotTaken;
            default:        nxt = taken ? strongTaken : weakTaken;
        endcase
        return nxt;
    endfunction

endpackage

/* common/memoryMapTypes.sv */
// Address layout of the fetch side
// Reset PC, instruction size and the word offset below line index and tag
package memoryMapTypes;

    // Address width of every PC in the front end
    localparam int PC_WIDTH = 32;

    // Fixed 32-bit instructions
    localparam int INSN_BYTES = 4;
    localparam int INSN_WIDTH = INSN_BYTES * 8;

    // Byte offset inside one word, index bits start above it
    localparam int WORD_OFFSET_BITS = $clog2(INSN_BYTES);

    // First fetch address after reset
    localparam logic [PC_WIDTH-1:0] RESET_PC = 32'h0000_1000;

endpackage

/* fetch/branchPredictor.sv */
`timescale 1ns/10ps
// Bimodal branch predictor with a BTB
// Parallel lookup for every fetch lane, one training write per cycle
module branchPredictor #(
    parameter int fetchWidth  = 2,
    parameter int predEntries = 16
) (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic [memoryMapTypes::PC_WIDTH-1:0] lanePc [fetchWidth],
    input  logic                                updValid,
    input  logic [memoryMapTypes::PC_WIDTH-1:0] updPc,
    input  logic                                updTaken,
    input  logic [memoryMapTypes::PC_WIDTH-1:0] updTarget,
    output logic                                predTaken [fetchWidth],
    output logic [memoryMapTypes::PC_WIDTH-1:0] btbTarget [fetchWidth]
);

    localparam int indexBits = $clog2(predEntries);
    localparam int tagBits   = memoryMapTypes::PC_WIDTH - memoryMapTypes::WORD_OFFSET_BITS
                               - indexBits;

    // Counter table and BTB share one index
    fetchTypes::CounterState             counter [predEntries];
    logic                                btbValid [predEntries];
    logic [tagBits-1:0]                  btbTag [predEntries];
    logic [memoryMapTypes::PC_WIDTH-1:0] btbTargetArr [predEntries];

    logic [indexBits-1:0] updIndex;
    logic [tagBits-1:0]   updTag;

    always_comb begin
        logic [indexBits-1:0] idx;
        logic [tagBits-1:0]   tag;
        for (int i = 0; i < fetchWidth; i++) begin
            idx = lanePc[i][memoryMapTypes::WORD_OFFSET_BITS +: indexBits];
            tag = lanePc[i][memoryMapTypes::PC_WIDTH-1 -: tagBits];
            // Taken only with a matching BTB entry to jump to
            predTaken[i] = (counter[idx] >= fetchTypes::weakTaken) && btbValid[idx]
                           && (btbTag[idx] == tag);
            btbTarget[i] = btbTargetArr[idx];
        end
    end

    assign updIndex = updPc[memoryMapTypes::WORD_OFFSET_BITS +: indexBits];
    assign updTag   = updPc[memoryMapTypes::PC_WIDTH-1 -: tagBits];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int e = 0; e < predEntries; e++) begin
                counter[e]  <= fetchTypes::COUNTER_INIT;
                btbValid[e] <= 1'b0;
            end
        end else if (updValid) begin
            counter[updIndex] <= fetchTypes::nextCounter(counter[updIndex], updTaken);
            if (updTaken) begin
                btbValid[updIndex] <= 1'b1;
            end
        end
    end

    // Tag and target written only by taken branches
    always_ff @(posedge clk) begin
        if (updValid && updTaken) begin
            btbTag[updIndex]       <= updTag;
            btbTargetArr[updIndex] <= updTarget;
        end
    end

endmodule

/* fetch/fetchStage.sv */
`timescale 1ns/10ps
// Fetch stage
// Holds one block of lanes, checks it in the instruction cache, attaches a
// prediction per lane and drops the lanes behind a predicted-taken branch
module fetchStage #(
    parameter int fetchWidth = 2
) (
    input  logic                                  clk,
    input  logic                                  arstN,
    input  logic                                  stall,
    input  logic                                  clear,
    input  logic [memoryMapTypes::PC_WIDTH-1:0]   blockPc,
    input  logic                                  blockValid,
    input  logic                                  icHit,
    input  logic [memoryMapTypes::INSN_WIDTH-1:0] icData [fetchWidth],
    input  logic                                  predTaken [fetchWidth],
    input  logic [memoryMapTypes::PC_WIDTH-1:0]   btbTarget [fetchWidth],
    output logic                                  fetchHold,
    output logic                                  icRead,
    output logic [memoryMapTypes::PC_WIDTH-1:0]   icAddr,
    output logic [memoryMapTypes::PC_WIDTH-1:0]   lanePc [fetchWidth],
    output logic                                  predTakenAny,
    output logic [memoryMapTypes::PC_WIDTH-1:0]   predTarget,
    output logic                                  outValid [fetchWidth],
    output logic [memoryMapTypes::PC_WIDTH-1:0]   outPc [fetchWidth],
    output logic [memoryMapTypes::INSN_WIDTH-1:0] outInsn [fetchWidth],
    output logic                                  outPredTaken [fetchWidth],
    output logic [memoryMapTypes::PC_WIDTH-1:0]   outPredAddr [fetchWidth]
);

    localparam int blockBytes = fetchWidth * memoryMapTypes::INSN_BYTES;
    localparam logic [memoryMapTypes::PC_WIDTH-1:0] blockMask = ~(blockBytes - 1);

    // Pipeline register, one valid and PC per lane
    logic                                laneValid [fetchWidth];
    logic [memoryMapTypes::PC_WIDTH-1:0] lanePcReg [fetchWidth];

    // Prediction captured when a stall begins
    logic                                regStall;
    logic                                beginStall;
    logic                                heldTaken [fetchWidth];
    logic [memoryMapTypes::PC_WIDTH-1:0] heldAddr [fetchWidth];

    // Prediction in effect this cycle
    logic                                effTaken [fetchWidth];
    logic [memoryMapTypes::PC_WIDTH-1:0] effAddr [fetchWidth];

    logic                                flushed [fetchWidth];
    logic                                anyValid;
    logic [memoryMapTypes::PC_WIDTH-1:0] alignedPc;
    int                                  startLane;

    // Live lookup, or the copy taken at stall start while the stall lasts
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            if (regStall) begin
                effTaken[i] = heldTaken[i];
                effAddr[i]  = heldAddr[i];
            end else begin
                effTaken[i] = predTaken[i];
                effAddr[i]  = predTaken[i] ? btbTarget[i]
                                           : lanePcReg[i] + memoryMapTypes::INSN_BYTES;
            end
        end
    end

    // First valid taken lane steers next PC, lanes after it are flushed
    always_comb begin
        logic seenTaken;
        seenTaken    = 1'b0;
        predTakenAny = 1'b0;
        predTarget   = '0;
        for (int i = 0; i < fetchWidth; i++) begin
            flushed[i] = laneValid[i] && seenTaken;
            if (laneValid[i] && effTaken[i] && !seenTaken) begin
                predTakenAny = 1'b1;
                predTarget   = effAddr[i];
            end
            seenTaken = seenTaken || (laneValid[i] && effTaken[i]);
        end
    end

    // Cache lookup uses the aligned PC of lane 0
    always_comb begin
        anyValid = 1'b0;
        for (int i = 0; i < fetchWidth; i++) begin
            anyValid = anyValid || laneValid[i];
        end
        icRead     = anyValid;
        icAddr     = lanePcReg[0];
        // Miss or external stall freezes both stages
        fetchHold  = stall || (anyValid && !icHit);
        beginStall = stall && !regStall;
        // Lanes below the offset of an unaligned block start are dropped
        alignedPc  = blockPc & blockMask;
        startLane  = int'((blockPc & ~blockMask) / memoryMapTypes::INSN_BYTES);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regStall <= 1'b0;
            for (int i = 0; i < fetchWidth; i++) begin
                laneValid[i] <= 1'b0;
                heldTaken[i] <= 1'b0;
            end
        end else begin
            regStall <= stall;
            for (int i = 0; i < fetchWidth; i++) begin
                if (clear) begin
                    laneValid[i] <= 1'b0;
                end else if (!fetchHold) begin
                    // Block behind a taken prediction is wrong path
                    laneValid[i] <= blockValid && !predTakenAny && (i >= startLane);
                end else if (stall && flushed[i]) begin
                    laneValid[i] <= 1'b0;
                end
                if (beginStall) begin
                    heldTaken[i] <= effTaken[i];
                end
            end
        end
    end

    // Lane PCs and held targets carry no reset
    always_ff @(posedge clk) begin
        for (int i = 0; i < fetchWidth; i++) begin
            if (!fetchHold) begin
                lanePcReg[i] <= alignedPc + i * memoryMapTypes::INSN_BYTES;
            end
            if (beginStall) begin
                heldAddr[i] <= effAddr[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            lanePc[i]       = lanePcReg[i];
            outValid[i]     = laneValid[i] && !flushed[i] && !fetchHold && !clear;
            outPc[i]        = lanePcReg[i];
            outInsn[i]      = icData[i];
            outPredTaken[i] = effTaken[i];
            outPredAddr[i]  = effAddr[i];
        end
    end

endmodule

/* fetch/nextPcStage.sv */
`timescale 1ns/10ps
// Next-PC stage
// Holds the address of the next fetch block and picks redirect, hold,
// predicted target or the next aligned block
module nextPcStage #(
    parameter int fetchWidth = 2
) (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                fetchHold,
    input  logic                                clear,
    input  logic [memoryMapTypes::PC_WIDTH-1:0] redirectPc,
    input  logic                                predTakenAny,
    input  logic [memoryMapTypes::PC_WIDTH-1:0] predTarget,
    output logic [memoryMapTypes::PC_WIDTH-1:0] blockPc,
    output logic                                blockValid
);

    localparam int blockBytes = fetchWidth * memoryMapTypes::INSN_BYTES;
    localparam logic [memoryMapTypes::PC_WIDTH-1:0] blockMask = ~(blockBytes - 1);

    fetchTypes::NextPcSel pcSel;
    logic [memoryMapTypes::PC_WIDTH-1:0] nextPc;

    // Redirect wins, then hold, then prediction
    always_comb begin
        if (clear) begin
            pcSel = fetchTypes::selRedirect;
        end else if (fetchHold || !blockValid) begin
            // First cycle after reset keeps RESET_PC for the fetch register
            pcSel = fetchTypes::selHold;
        end else if (predTakenAny) begin
            pcSel = fetchTypes::selPredicted;
        end else begin
            pcSel = fetchTypes::selSequential;
        end
    end

    always_comb begin
        case (pcSel)
            fetchTypes::selRedirect:  nextPc = redirectPc;
            fetchTypes::selHold:      nextPc = blockPc;
            fetchTypes::selPredicted: nextPc = predTarget;
            default:                  nextPc = (blockPc & blockMask) + blockBytes;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            blockPc    <= memoryMapTypes::RESET_PC;
            blockValid <= 1'b0;
        end else begin
            blockPc    <= nextPc;
            blockValid <= 1'b1;
        end
    end

endmodule

/* fetchFrontEnd.f */
common/fetchTypes.sv
common/memoryMapTypes.sv
fetch/nextPcStage.sv
fetch/fetchStage.sv
fetch/branchPredictor.sv
source/instCache.sv
source/fetchFrontEnd.sv
verification/fetchFrontEndTb.sv

/* source/fetchFrontEnd.sv */
`timescale 1ns/10ps
// Instruction fetch front end
// Next-PC stage, fetch stage, bimodal predictor and instruction cache
module fetchFrontEnd #(
    parameter int fetchWidth  = 2,
    parameter int cacheLines  = 8,
    parameter int predEntries = 16
) (
    input  logic                                  clk,
    input  logic                                  arstN,
    input  logic                                  stall,
    input  logic                                  clear,
    input  logic [memoryMapTypes::PC_WIDTH-1:0]   redirectPc,
    input  logic                                  updValid,
    input  logic [memoryMapTypes::PC_WIDTH-1:0]   updPc,
    input  logic                                  updTaken,
    input  logic [memoryMapTypes::PC_WIDTH-1:0]   updTarget,
    input  logic                                  memValid,
    input  logic [memoryMapTypes::INSN_WIDTH-1:0] memLine [fetchWidth],
    output logic                                  memReq,
    output logic [memoryMapTypes::PC_WIDTH-1:0]   memAddr,
    output logic                                  outValid [fetchWidth],
    output logic [memoryMapTypes::PC_WIDTH-1:0]   outPc [fetchWidth],
    output logic [memoryMapTypes::INSN_WIDTH-1:0] outInsn [fetchWidth],
    output logic                                  outPredTaken [fetchWidth],
    output logic [memoryMapTypes::PC_WIDTH-1:0]   outPredAddr [fetchWidth]
);

    // Between next-PC and fetch
    logic [memoryMapTypes::PC_WIDTH-1:0]   blockPc;
    logic                                  blockValid;
    logic                                  fetchHold;
    logic                                  predTakenAny;
    logic [memoryMapTypes::PC_WIDTH-1:0]   predTarget;

    // Cache and predictor lookups
    logic                                  icRead;
    logic [memoryMapTypes::PC_WIDTH-1:0]   icAddr;
    logic                                  icHit;
    logic [memoryMapTypes::INSN_WIDTH-1:0] icData [fetchWidth];
    logic [memoryMapTypes::PC_WIDTH-1:0]   lanePc [fetchWidth];
    logic                                  predTaken [fetchWidth];
    logic [memoryMapTypes::PC_WIDTH-1:0]   btbTarget [fetchWidth];

    nextPcStage #(.fetchWidth(fetchWidth)) u_nextPcStage (
        .clk(clk), .arstN(arstN), .fetchHold(fetchHold), .clear(clear),
        .redirectPc(redirectPc), .predTakenAny(predTakenAny), .predTarget(predTarget),
        .blockPc(blockPc), .blockValid(blockValid)
    );

    fetchStage #(.fetchWidth(fetchWidth)) u_fetchStage (
        .clk(clk), .arstN(arstN), .stall(stall), .clear(clear),
        .blockPc(blockPc), .blockValid(blockValid), .icHit(icHit), .icData(icData),
        .predTaken(predTaken), .btbTarget(btbTarget), .fetchHold(fetchHold),
        .icRead(icRead), .icAddr(icAddr), .lanePc(lanePc),
        .predTakenAny(predTakenAny), .predTarget(predTarget),
        .outValid(outValid), .outPc(outPc), .outInsn(outInsn),
        .outPredTaken(outPredTaken), .outPredAddr(outPredAddr)
    );

    branchPredictor #(.fetchWidth(fetchWidth), .predEntries(predEntries)) u_branchPredictor (
        .clk(clk), .arstN(arstN), .lanePc(lanePc),
        .updValid(updValid), .updPc(updPc), .updTaken(updTaken), .updTarget(updTarget),
        .predTaken(predTaken), .btbTarget(btbTarget)
    );

    instCache #(.fetchWidth(fetchWidth), .cacheLines(cacheLines)) u_instCache (
        .clk(clk), .arstN(arstN), .clear(clear), .icRead(icRead), .icAddr(icAddr),
        .memValid(memValid), .memLine(memLine), .icHit(icHit), .icData(icData),
        .memReq(memReq), .memAddr(memAddr)
    );

endmodule

/* source/instCache.sv */
`timescale 1ns/10ps
// Direct-mapped instruction cache
// One fetch block per line, refilled whole from the memory port on a miss
module instCache #(
    parameter int fetchWidth = 2,
    parameter int cacheLines = 8
) (
    input  logic                                  clk,
    input  logic                                  arstN,
    input  logic                                  clear,
    input  logic                                  icRead,
    input  logic [memoryMapTypes::PC_WIDTH-1:0]   icAddr,
    input  logic                                  memValid,
    input  logic [memoryMapTypes::INSN_WIDTH-1:0] memLine [fetchWidth],
    output logic                                  icHit,
    output logic [memoryMapTypes::INSN_WIDTH-1:0] icData [fetchWidth],
    output logic                                  memReq,
    output logic [memoryMapTypes::PC_WIDTH-1:0]   memAddr
);

    localparam int offsetBits = $clog2(fetchWidth * memoryMapTypes::INSN_BYTES);
    localparam int indexBits  = $clog2(cacheLines);
    localparam int tagBits    = memoryMapTypes::PC_WIDTH - offsetBits - indexBits;

    fetchTypes::CacheState state;

    logic                                  lineValid [cacheLines];
    logic [tagBits-1:0]                    lineTag [cacheLines];
    logic [memoryMapTypes::INSN_WIDTH-1:0] lineData [cacheLines][fetchWidth];
    logic [memoryMapTypes::PC_WIDTH-1:0]   missAddr;

    logic [indexBits-1:0] readIndex;
    logic [indexBits-1:0] fillIndex;
    logic [tagBits-1:0]   readTag;
    logic [tagBits-1:0]   fillTag;

    assign readIndex = icAddr[offsetBits +: indexBits];
    assign readTag   = icAddr[memoryMapTypes::PC_WIDTH-1 -: tagBits];
    assign fillIndex = missAddr[offsetBits +: indexBits];
    assign fillTag   = missAddr[memoryMapTypes::PC_WIDTH-1 -: tagBits];

    // Hit and data straight from the arrays
    always_comb begin
        icHit = lineValid[readIndex] && (lineTag[readIndex] == readTag);
        for (int i = 0; i < fetchWidth; i++) begin
            icData[i] = lineData[readIndex][i];
        end
    end

    // Request held as a level for the whole refill
    assign memReq  = (state == fetchTypes::refill);
    assign memAddr = missAddr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= fetchTypes::idle;
            for (int l = 0; l < cacheLines; l++) begin
                lineValid[l] <= 1'b0;
            end
        end else begin
            case (state)
                fetchTypes::idle: begin
                    // No refill for a block that is being cleared
                    if (icRead && !icHit && !clear) begin
                        state <= fetchTypes::refill;
                    end
                end
                default: begin
                    // Refill finishes even across a clear
                    if (memValid) begin
                        lineValid[fillIndex] <= 1'b1;
                        state                <= fetchTypes::idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetchTypes::idle && icRead && !icHit) begin
            missAddr <= icAddr;
        end
        if (state == fetchTypes::refill && memValid) begin
            lineTag[fillIndex] <= fillTag;
            for (int i = 0; i < fetchWidth; i++) begin
                lineData[fillIndex][i] <= memLine[i];
            end
        end
    end

endmodule

/* verification/fetchFrontEndTb.sv */
`timescale 1ns/10ps
// Testbench for the fetch front end
// Memory model with random refill delay, reference fetch stream with its own
// branch table, and a checker that compares every valid output lane
module fetchFrontEndTb;

    localparam int fetchWidth = 2;
    localparam int cycleLimit = 4000;
    // Trained branches live in one 16-word window, one predictor entry each
    localparam logic [31:0] trainBase = 32'h0000_3000;

    logic        clk = 1'b0;
    logic        arstN;
    logic        stall;
    logic        clear;
    logic [31:0] redirectPc;
    logic        updValid;
    logic [31:0] updPc;
    logic        updTaken;
    logic [31:0] updTarget;
    logic        memValid;
    logic [31:0] memLine [fetchWidth];
    logic        memReq;
    logic [31:0] memAddr;
    logic        outValid [fetchWidth];
    logic [31:0] outPc [fetchWidth];
    logic [31:0] outInsn [fetchWidth];
    logic        outPredTaken [fetchWidth];
    logic [31:0] outPredAddr [fetchWidth];

    // Reference branch table, live and as captured at stall start
    fetchTypes::CounterState ctr [16];
    logic        hasTgt [16];
    logic [31:0] tgt [16];
    fetchTypes::CounterState heldCtr [16];
    logic        heldHas [16];
    logic [31:0] heldTgt [16];
    logic        prevStall = 1'b0;

    logic [31:0] expNext = memoryMapTypes::RESET_PC;
    logic [31:0] lfsr = 32'h3e98;
    int          memWait = -1;
    int          afterReset = 0;
    int          seenCount = 0;
    int          errors = 0;
    int          testErrors = 0;
    int          testCount = 0;
    int          cycleCount = 0;

    fetchFrontEnd #(.fetchWidth(fetchWidth), .cacheLines(8), .predEntries(16)) u_fetchFrontEnd (
        .clk(clk), .arstN(arstN), .stall(stall), .clear(clear), .redirectPc(redirectPc),
        .updValid(updValid), .updPc(updPc), .updTaken(updTaken), .updTarget(updTarget),
        .memValid(memValid), .memLine(memLine), .memReq(memReq), .memAddr(memAddr),
        .outValid(outValid), .outPc(outPc), .outInsn(outInsn),
        .outPredTaken(outPredTaken), .outPredAddr(outPredAddr)
    );

    always #50 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Memory contents, a fixed mix of the whole address
    function automatic logic [31:0] memoryWord(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ (a >> 7) ^ 32'h5a5a_0000;
    endfunction

    // Expected prediction of one PC from the reference table
    function automatic void expectedPred(input logic [31:0] pc, input logic held,
                                         output logic taken, output logic [31:0] addr);
        int k;
        k = pc[5:2];
        taken = 1'b0;
        addr  = pc + memoryMapTypes::INSN_BYTES;
        if ((pc & ~32'h3f) == trainBase) begin
            if (held && heldCtr[k] >= fetchTypes::weakTaken && heldHas[k]) begin
                taken = 1'b1;
                addr  = heldTgt[k];
            end else if (!held && ctr[k] >= fetchTypes::weakTaken && hasTgt[k]) begin
                taken = 1'b1;
                addr  = tgt[k];
            end
        end
    endfunction

    task automatic mismatch(input string name, input int lane,
                            input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("Mismatch %s lane %0d: got %h expected %h", name, lane, got, exp);
    endtask

    // Sampled just before the rising edge, after the inputs have settled
    task automatic checkCycle();
        logic        taken;
        logic [31:0] addr;
        int          k;
        // Reset and the two cycles after it, before the first block is loaded
        if (!arstN || afterReset < 2) begin
            for (int i = 0; i < fetchWidth; i++) begin
                if (outValid[i]) begin
                    errors++;
                    $display("Lane %0d shows a valid instruction during or just after reset", i);
                end
            end
            if (memReq) begin
                errors++;
                $display("Memory request raised during or just after reset");
            end
            if (arstN) begin
                afterReset++;
            end
        end else begin
            for (int i = 0; i < fetchWidth; i++) begin
                if (outValid[i]) begin
                    seenCount++;
                    expectedPred(expNext, prevStall, taken, addr);
                    if (outPc[i] !== expNext) begin
                        mismatch("outPc", i, outPc[i], expNext);
                    end
                    if (outInsn[i] !== memoryWord(expNext)) begin
                        mismatch("outInsn", i, outInsn[i], memoryWord(expNext));
                    end
                    if (outPredTaken[i] !== taken) begin
                        mismatch("outPredTaken", i, outPredTaken[i], taken);
                    end
                    if (outPredAddr[i] !== addr) begin
                        mismatch("outPredAddr", i, outPredAddr[i], addr);
                    end
                    expNext = addr;
                end
            end
            if (clear) begin
                expNext = redirectPc;
            end
            // Snapshot before this cycle's training takes effect
            if (stall && !prevStall) begin
                heldCtr = ctr;
                heldHas = hasTgt;
                heldTgt = tgt;
            end
            if (updValid && (updPc & ~32'h3f) == trainBase) begin
                k = updPc[5:2];
                if (updTaken) begin
                    if (ctr[k] != fetchTypes::strongTaken) begin
                        ctr[k] = fetchTypes::CounterState'(int'(ctr[k]) + 1);
                    end
                    hasTgt[k] = 1'b1;
                    tgt[k]    = updTarget;
                end else if (ctr[k] != fetchTypes::strongNotTaken) begin
                    ctr[k] = fetchTypes::CounterState'(int'(ctr[k]) - 1);
                end
            end
            prevStall = stall;
        end
    endtask

    always begin
        @(negedge clk);
        #45;
        checkCycle();
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Falling edge, then answer an open refill after 1 to 4 cycles
    task automatic tick();
        @(negedge clk);
        memValid = 1'b0;
        if (memReq) begin
            if (memWait < 0) begin
                memWait = int'(randBits(2));
            end
            if (memWait == 0) begin
                for (int i = 0; i < fetchWidth; i++) begin
                    memLine[i] = memoryWord(memAddr + i * memoryMapTypes::INSN_BYTES);
                end
                memValid = 1'b1;
                memWait  = -1;
            end else begin
                memWait--;
            end
        end
    endtask

    task automatic redirect(input logic [31:0] pc);
        tick();
        clear      = 1'b1;
        redirectPc = pc;
        tick();
        clear = 1'b0;
    endtask

    task automatic train(input logic [31:0] pc, input logic taken, input logic [31:0] target);
        tick();
        updValid  = 1'b1;
        updPc     = pc;
        updTaken  = taken;
        updTarget = target;
        tick();
        updValid = 1'b0;
    endtask

    task automatic waitOutputs(input int n);
        int target;
        target = seenCount + n;
        while (seenCount < target) begin
            tick();
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("%s finished with %0d errors", name, errors - testErrors);
        testErrors = errors;
    endtask

    initial begin
        arstN      = 1'b0;
        stall      = 1'b0;
        clear      = 1'b0;
        redirectPc = '0;
        updValid   = 1'b0;
        updPc      = '0;
        updTaken   = 1'b0;
        updTarget  = '0;
        memValid   = 1'b0;
        for (int i = 0; i < fetchWidth; i++) begin
            memLine[i] = '0;
        end
        for (int k = 0; k < 16; k++) begin
            ctr[k]    = fetchTypes::weakNotTaken;
            hasTgt[k] = 1'b0;
            tgt[k]    = '0;
        end
        repeat (5) tick();
        arstN = 1'b1;
        waitOutputs(2);
        finishTest("reset state");

        // Untrained stream over all eight lines, the next block refills line 0
        // so lines 1 to 6 are refetched straight from the cache
        waitOutputs(14);
        redirect(memoryMapTypes::RESET_PC + 32'h8);
        waitOutputs(12);
        finishTest("sequential fetch");

        redirect(32'h0000_2000);
        waitOutputs(6);
        redirect(32'h0000_2104);
        waitOutputs(6);
        finishTest("redirect");

        // X in lane 0, target away from the fall-through
        train(trainBase, 1'b1, 32'h0000_3404);
        redirect(trainBase);
        waitOutputs(4);
        train(trainBase, 1'b0, 32'h0);
        redirect(trainBase);
        waitOutputs(4);
        finishTest("prediction and flush");

        train(trainBase, 1'b1, 32'h0000_3404);
        redirect(trainBase);
        tick();
        stall = 1'b1;
        repeat (2) tick();
        train(trainBase, 1'b0, 32'h0);
        repeat (2) tick();
        stall = 1'b0;
        waitOutputs(4);
        finishTest("stall with training");

        repeat (300) begin
            tick();
            stall    = (randBits(2) == 0);
            clear    = (randBits(5) == 0);
            updValid = (randBits(3) == 0);
            redirectPc = trainBase | (randBits(7) << 2);
            updPc      = trainBase | (randBits(4) << 2);
            updTaken   = randBits(1);
            updTarget  = trainBase | (randBits(7) << 2);
        end
        tick();
        stall    = 1'b0;
        clear    = 1'b0;
        updValid = 1'b0;
        waitOutputs(4);
        finishTest("random mix");

        $display("%0d tests, %0d lanes checked, %0d errors", testCount, seenCount, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
